/* enq_pkg.sv */
// shared widths and encodings; QID_W sets NUM_Q, and BYTES_W must be at least LEN_W

package enq_pkg;

	// ======================================================================
	// widths
	// ======================================================================

	// queue number width, four queues by default
	localparam int QID_W = 2;

	// packet length in bytes, up to 2047
	localparam int LEN_W = 11;

	// per-queue byte counter and byte limit
	localparam int BYTES_W = 16;

	// number of queues follows from the qid width
	localparam int NUM_Q = 1 << QID_W;

	// ======================================================================
	// command opcode
	// ======================================================================

	// enqueue adds bytes and one packet
	// dequeue removes bytes and one packet
	typedef enum logic {
		OP_ENQ = 1'b0,
		OP_DEQ = 1'b1
	} enq_op_e;

	// ======================================================================
	// result verdict
	// ======================================================================

	// ok means the counters were updated
	// drop is an enqueue over the byte limit
	// underflow is a dequeue with no packet or too few bytes
	typedef enum logic [1:0] {
		VD_OK        = 2'd0,
		VD_DROP      = 2'd1,
		VD_UNDERFLOW = 2'd2
	} enq_verdict_e;

endpackage

/* fifo_ctrl.sv */
// pointer and flag controller; caller must never write while full or read while empty

`timescale 1ns/100ps

module fifo_ctrl #(
	parameter int FIFO_DEPTH_NBITS = 3
) (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        rd,
	input  logic                        wr,
	output logic [FIFO_DEPTH_NBITS-1:0] rptr,
	output logic [FIFO_DEPTH_NBITS-1:0] wptr,
	output logic [FIFO_DEPTH_NBITS:0]   count,
	output logic                        full,
	output logic                        empty
);

	localparam int DEPTH = 1 << FIFO_DEPTH_NBITS;

	// accepted requests only
	logic                      rd_ok;
	logic                      wr_ok;
	logic [FIFO_DEPTH_NBITS:0] count_nxt;

	assign rd_ok = rd && !empty;
	assign wr_ok = wr && !full;

	// occupancy after this edge
	always_comb begin
		count_nxt = count;
		if (wr_ok && !rd_ok)
			count_nxt = count + (FIFO_DEPTH_NBITS+1)'(1);
		else if (rd_ok && !wr_ok)
			count_nxt = count - (FIFO_DEPTH_NBITS+1)'(1);
	end

	// ======================================================================
	// pointers, count and flags
	// ======================================================================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rptr  <= '0;
			wptr  <= '0;
			count <= '0;
			full  <= 1'b0;
			empty <= 1'b1;
		end else begin
			// pointers wrap naturally at the power-of-two depth
			if (rd_ok)
				rptr <= rptr + FIFO_DEPTH_NBITS'(1);
			if (wr_ok)
				wptr <= wptr + FIFO_DEPTH_NBITS'(1);
			count <= count_nxt;
			// flags registered from next count
			full  <= (count_nxt == DEPTH[FIFO_DEPTH_NBITS:0]);
			empty <= (count_nxt == '0);
		end
	end

	// upstream logic must respect the flags it was given last edge
	a_no_overrun: assert property (@(posedge clk) disable iff (!arst_n)
		!(wr && full) && !(rd && empty))
		else $error("fifo_ctrl access past full or empty");

endmodule

/* enq_cmd_fifo.sv */
// command FIFO with registered head; holds 2**FIFO_DEPTH_NBITS entries plus the head

`timescale 1ns/100ps

module enq_cmd_fifo #(
	parameter int FIFO_DEPTH_NBITS = 3
) (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       push,
	input  enq_pkg::enq_op_e           push_op,
	input  logic [enq_pkg::QID_W-1:0]  push_qid,
	input  logic [enq_pkg::LEN_W-1:0]  push_len,
	input  logic                       pop,
	output logic                       head_valid,
	output enq_pkg::enq_op_e           head_op,
	output logic [enq_pkg::QID_W-1:0]  head_qid,
	output logic [enq_pkg::LEN_W-1:0]  head_len,
	output logic                       full
);

	import enq_pkg::*;

	localparam int DEPTH = 1 << FIFO_DEPTH_NBITS;
	// entry layout is op, qid, len from msb down
	localparam int ENT_W = 1 + QID_W + LEN_W;

	logic [ENT_W-1:0]            push_ent;
	logic [ENT_W-1:0]            head_q;
	logic [ENT_W-1:0]            mem [DEPTH];
	logic [ENT_W-1:0]            mem_rd;
	logic                        mem_rd_en;
	logic                        mem_wr_en;
	logic [FIFO_DEPTH_NBITS-1:0] mem_rptr;
	logic [FIFO_DEPTH_NBITS-1:0] mem_wptr;
	logic [FIFO_DEPTH_NBITS:0]   mem_count;
	logic                        mem_full;
	logic                        mem_empty;
	logic                        head_ld;

	assign push_ent = {push_op, push_qid, push_len};

	// ======================================================================
	// memory behind the head
	// ======================================================================

	// pop refills head from memory when memory has data
	assign mem_rd_en = pop && !mem_empty;
	// push bypasses memory if head is free or drains this edge
	assign mem_wr_en = push && head_valid && !(pop && mem_empty);

	fifo_ctrl #(
		.FIFO_DEPTH_NBITS(FIFO_DEPTH_NBITS)
	) u_fifo_ctrl (
		.clk   (clk),
		.arst_n(arst_n),
		.rd    (mem_rd_en),
		.wr    (mem_wr_en),
		.rptr  (mem_rptr),
		.wptr  (mem_wptr),
		.count (mem_count),
		.full  (mem_full),
		.empty (mem_empty)
	);

	always_ff @(posedge clk) begin
		if (mem_wr_en)
			mem[mem_wptr] <= push_ent;
	end

	assign mem_rd = mem[mem_rptr];

	// ======================================================================
	// head register
	// ======================================================================

	assign head_ld = mem_rd_en || (push && (!head_valid || (pop && mem_empty)));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			head_valid <= 1'b0;
		else if (pop)
			head_valid <= !mem_empty || push;
		else if (push)
			head_valid <= 1'b1;
	end

	// older memory entry wins over a same-edge push
	always_ff @(posedge clk) begin
		if (head_ld)
			head_q <= mem_rd_en ? mem_rd : push_ent;
	end

	assign head_op  = enq_op_e'(head_q[ENT_W-1]);
	assign head_qid = head_q[LEN_W +: QID_W];
	assign head_len = head_q[LEN_W-1:0];

	// only full when both head and memory are taken
	assign full = head_valid && mem_full;

	a_push_pop_legal: assert property (@(posedge clk) disable iff (!arst_n)
		!(push && full) && !(pop && !head_valid))
		else $error("enq_cmd_fifo push while full or pop while empty");

	// memory never holds data behind an empty head
	a_head_first: assert property (@(posedge clk) disable iff (!arst_n)
		(mem_count != '0) |-> head_valid)
		else $error("enq_cmd_fifo memory occupied with empty head");

endmodule

/* queue_limit_regs.sv */
// per-queue byte limits; a write is seen by the read port from the next cycle

`timescale 1ns/100ps

module queue_limit_regs #(
	parameter logic [enq_pkg::BYTES_W-1:0] DEFAULT_LIMIT = 16'd4096
) (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         cfg_wr,
	input  logic [enq_pkg::QID_W-1:0]    cfg_qid,
	input  logic [enq_pkg::BYTES_W-1:0]  cfg_limit,
	input  logic [enq_pkg::QID_W-1:0]    lim_qid,
	output logic [enq_pkg::BYTES_W-1:0]  lim_value
);

	import enq_pkg::*;

	// one limit per queue
	logic [BYTES_W-1:0] limit_q [NUM_Q];

	// ======================================================================
	// write side
	// ======================================================================

	// every queue starts at the default limit
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_Q; i++)
				limit_q[i] <= DEFAULT_LIMIT;
		end else if (cfg_wr) begin
			// register write always completes
			limit_q[cfg_qid] <= cfg_limit;
		end
	end

	// ======================================================================
	// read side
	// ======================================================================

	// combinational lookup for the engine
	assign lim_value = limit_q[lim_qid];

endmodule

/* enq_engine.sv */
// enqueue engine; one command per cycle, result held while out_ready is low

`timescale 1ns/100ps

module enq_engine (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic                          fifo_valid,
	input  enq_pkg::enq_op_e              fifo_op,
	input  logic [enq_pkg::QID_W-1:0]     fifo_qid,
	input  logic [enq_pkg::LEN_W-1:0]     fifo_len,
	input  logic [enq_pkg::BYTES_W-1:0]   lim_value,
	input  logic                          out_ready,
	output logic                          fifo_pop,
	output logic [enq_pkg::QID_W-1:0]     lim_qid,
	output logic                          out_valid,
	output enq_pkg::enq_op_e              out_op,
	output logic [enq_pkg::QID_W-1:0]     out_qid,
	output enq_pkg::enq_verdict_e         out_verdict,
	output logic [enq_pkg::BYTES_W-1:0]   out_bytes
);

	import enq_pkg::*;

	// packet counter sized like the byte counter
	localparam int PKT_W = BYTES_W;

	logic [BYTES_W-1:0] bytes_q [NUM_Q];
	logic [PKT_W-1:0]   pkts_q  [NUM_Q];
	logic [BYTES_W-1:0] cur_bytes;
	logic [PKT_W-1:0]   cur_pkts;
	logic [BYTES_W-1:0] len_ext;
	logic [BYTES_W:0]   enq_sum;
	logic [BYTES_W-1:0] new_bytes;
	logic [PKT_W-1:0]   new_pkts;
	enq_verdict_e       verdict;

	// take a new head when the output slot is free or draining
	assign fifo_pop = fifo_valid && (!out_valid || out_ready);

	// limit lookup follows the head
	assign lim_qid = fifo_qid;

	assign cur_bytes = bytes_q[fifo_qid];
	assign cur_pkts  = pkts_q[fifo_qid];
	assign len_ext   = {{(BYTES_W-LEN_W){1'b0}}, fifo_len};
	// one extra bit so the limit test sees wrap
	assign enq_sum   = {1'b0, cur_bytes} + {1'b0, len_ext};

	// ======================================================================
	// verdict
	// ======================================================================

	always_comb begin
		verdict   = VD_OK;
		new_bytes = cur_bytes;
		new_pkts  = cur_pkts;
		unique case (fifo_op)
			OP_ENQ: begin
				if (enq_sum <= {1'b0, lim_value}) begin
					new_bytes = enq_sum[BYTES_W-1:0];
					new_pkts  = cur_pkts + PKT_W'(1);
				end else begin
					verdict = VD_DROP;
				end
			end
			OP_DEQ: begin
				// needs a packet and enough bytes
				if (cur_pkts != '0 && cur_bytes >= len_ext) begin
					new_bytes = cur_bytes - len_ext;
					new_pkts  = cur_pkts - PKT_W'(1);
				end else begin
					verdict = VD_UNDERFLOW;
				end
			end
		endcase
	end

	// ======================================================================
	// counters and result register
	// ======================================================================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_Q; i++) begin
				bytes_q[i] <= '0;
				pkts_q[i]  <= '0;
			end
		end else if (fifo_pop && verdict == VD_OK) begin
			bytes_q[fifo_qid] <= new_bytes;
			pkts_q[fifo_qid]  <= new_pkts;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			out_valid <= 1'b0;
		else if (fifo_pop)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	// payload loads with the pop, else holds
	always_ff @(posedge clk) begin
		if (fifo_pop) begin
			out_op      <= fifo_op;
			out_qid     <= fifo_qid;
			out_verdict <= verdict;
			out_bytes   <= new_bytes;
		end
	end

	a_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=>
			out_valid && $stable({out_op, out_qid, out_verdict, out_bytes}))
		else $error("enq_engine result changed under back-pressure");

endmodule

/* enq_top.sv */
// queue manager enqueue path; result appears two cycles after an idle accept

`timescale 1ns/100ps

module enq_top #(
	parameter int                          FIFO_DEPTH_NBITS = 3,
	parameter logic [enq_pkg::BYTES_W-1:0] DEFAULT_LIMIT    = 16'd4096
) (
	input  logic                          clk,
	input  logic                          arst_n,
	// command stream
	input  logic                          in_valid,
	input  enq_pkg::enq_op_e              in_op,
	input  logic [enq_pkg::QID_W-1:0]     in_qid,
	input  logic [enq_pkg::LEN_W-1:0]     in_len,
	output logic                          in_ready,
	// limit writes
	input  logic                          cfg_wr,
	input  logic [enq_pkg::QID_W-1:0]     cfg_qid,
	input  logic [enq_pkg::BYTES_W-1:0]   cfg_limit,
	// result stream
	input  logic                          out_ready,
	output logic                          out_valid,
	output enq_pkg::enq_op_e              out_op,
	output logic [enq_pkg::QID_W-1:0]     out_qid,
	output enq_pkg::enq_verdict_e         out_verdict,
	output logic [enq_pkg::BYTES_W-1:0]   out_bytes
);

	import enq_pkg::*;

	logic               fifo_full;
	logic               fifo_push;
	logic               fifo_valid;
	enq_op_e            fifo_op;
	logic [QID_W-1:0]   fifo_qid;
	logic [LEN_W-1:0]   fifo_len;
	logic               fifo_pop;
	logic [QID_W-1:0]   lim_qid;
	logic [BYTES_W-1:0] lim_value;

	// ======================================================================
	// command handshake
	// ======================================================================

	assign in_ready  = !fifo_full;
	assign fifo_push = in_valid && in_ready;

	enq_cmd_fifo #(
		.FIFO_DEPTH_NBITS(FIFO_DEPTH_NBITS)
	) u_cmd_fifo (
		.clk       (clk),
		.arst_n    (arst_n),
		.push      (fifo_push),
		.push_op   (in_op),
		.push_qid  (in_qid),
		.push_len  (in_len),
		.pop       (fifo_pop),
		.head_valid(fifo_valid),
		.head_op   (fifo_op),
		.head_qid  (fifo_qid),
		.head_len  (fifo_len),
		.full      (fifo_full)
	);

	queue_limit_regs #(
		.DEFAULT_LIMIT(DEFAULT_LIMIT)
	) u_limits (
		.clk      (clk),
		.arst_n   (arst_n),
		.cfg_wr   (cfg_wr),
		.cfg_qid  (cfg_qid),
		.cfg_limit(cfg_limit),
		.lim_qid  (lim_qid),
		.lim_value(lim_value)
	);

	enq_engine u_engine (
		.clk        (clk),
		.arst_n     (arst_n),
		.fifo_valid (fifo_valid),
		.fifo_op    (fifo_op),
		.fifo_qid   (fifo_qid),
		.fifo_len   (fifo_len),
		.lim_value  (lim_value),
		.out_ready  (out_ready),
		.fifo_pop   (fifo_pop),
		.lim_qid    (lim_qid),
		.out_valid  (out_valid),
		.out_op     (out_op),
		.out_qid    (out_qid),
		.out_verdict(out_verdict),
		.out_bytes  (out_bytes)
	);

endmodule

/* tb_enq_top.sv */
// self-checking testbench; limit writes go out only while the DUT is idle

`timescale 1ns/100ps

module tb_enq_top;

	import enq_pkg::*;

	localparam int DEF_LIMIT = 4096;
	// command total over all tests with the back-pressure burst capped at 16
	localparam int NUM_CMDS  = 4 + 4 + 4 + 1 + 16 + 300;
	localparam int TIMEOUT   = NUM_CMDS * 20 + 200;

	logic               clk;
	logic               arst_n;
	logic               in_valid;
	enq_op_e            in_op;
	logic [QID_W-1:0]   in_qid;
	logic [LEN_W-1:0]   in_len;
	logic               in_ready;
	logic               cfg_wr;
	logic [QID_W-1:0]   cfg_qid;
	logic [BYTES_W-1:0] cfg_limit;
	logic               out_ready;
	logic               out_valid;
	enq_op_e            out_op;
	logic [QID_W-1:0]   out_qid;
	enq_verdict_e       out_verdict;
	logic [BYTES_W-1:0] out_bytes;

	int           seed     = 32'hc9d2ef0f;
	int           errors   = 0;
	int           checked  = 0;
	int           cycles   = 0;
	// out_ready mode 0 is high, 1 held low, 2 random stalls
	int           rdy_mode = 0;
	string        test_name;
	int           sent_op[$];
	int           sent_qid[$];
	int           sent_len[$];
	int           ref_bytes[NUM_Q];
	int           ref_pkts[NUM_Q];
	int           ref_limit[NUM_Q];
	enq_verdict_e last_verdict;
	int           last_bytes;

	enq_top #(
		.FIFO_DEPTH_NBITS(3),
		.DEFAULT_LIMIT   (16'd4096)
	) u_dut (
		.clk        (clk),
		.arst_n     (arst_n),
		.in_valid   (in_valid),
		.in_op      (in_op),
		.in_qid     (in_qid),
		.in_len     (in_len),
		.in_ready   (in_ready),
		.cfg_wr     (cfg_wr),
		.cfg_qid    (cfg_qid),
		.cfg_limit  (cfg_limit),
		.out_ready  (out_ready),
		.out_valid  (out_valid),
		.out_op     (out_op),
		.out_qid    (out_qid),
		.out_verdict(out_verdict),
		.out_bytes  (out_bytes)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ======================================================================
	// reference model
	// ======================================================================

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// enq fits under the limit, deq needs a packet and enough bytes
	function automatic void ref_apply(input int op, input int qid, input int len,
			output enq_verdict_e verdict, output int bytes);
		verdict = VD_OK;
		if (op == int'(OP_ENQ)) begin
			if (ref_bytes[qid] + len <= ref_limit[qid]) begin
				ref_bytes[qid] += len;
				ref_pkts[qid]  += 1;
			end else begin
				verdict = VD_DROP;
			end
		end else begin
			if (ref_pkts[qid] > 0 && ref_bytes[qid] >= len) begin
				ref_bytes[qid] -= len;
				ref_pkts[qid]  -= 1;
			end else begin
				verdict = VD_UNDERFLOW;
			end
		end
		bytes = ref_bytes[qid];
	endfunction

	// ======================================================================
	// drivers and checker
	// ======================================================================

	// mode sampled at the edge, applied 1 ns later
	initial begin
		int m;
		int r;
		forever begin
			@(posedge clk);
			m = rdy_mode;
			r = rand_below(4);
			#1;
			out_ready = (m == 0) || (m == 2 && r != 0);
		end
	end

	// sampled at negedge once handshakes have settled
	always @(negedge clk) begin
		int           op;
		int           qid;
		int           len;
		enq_verdict_e exp_v;
		int           exp_b;
		if (arst_n && out_valid && out_ready) begin
			if (sent_op.size() == 0) begin
				errors++;
				$display("result seen with no command pending in test %s", test_name);
			end else begin
				op  = sent_op.pop_front();
				qid = sent_qid.pop_front();
				len = sent_len.pop_front();
				ref_apply(op, qid, len, exp_v, exp_b);
				checked++;
				assert (int'(out_op) == op && int'(out_qid) == qid &&
					out_verdict == exp_v && int'(out_bytes) == exp_b)
				else begin
					errors++;
					$write("[FAIL] %s: expected op %0d qid %0d %s bytes %0d, ",
						test_name, op, qid, exp_v.name(), exp_b);
					$display("actual op %0d qid %0d %s bytes %0d",
						out_op, out_qid, out_verdict.name(), out_bytes);
				end
				last_verdict = out_verdict;
				last_bytes   = int'(out_bytes);
			end
		end
		// accepted commands, in order
		if (arst_n && in_valid && in_ready) begin
			sent_op.push_back(int'(in_op));
			sent_qid.push_back(int'(in_qid));
			sent_len.push_back(int'(in_len));
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// idle for gap cycles, then hold the command until accepted
	task automatic send_cmd(input int op, input int qid, input int len, input int gap);
		repeat (gap) begin
			@(posedge clk);
			#1;
		end
		in_valid = 1'b1;
		in_op    = (op == int'(OP_ENQ)) ? OP_ENQ : OP_DEQ;
		in_qid   = QID_W'(qid);
		in_len   = LEN_W'(len);
		do
			@(negedge clk);
		while (!in_ready);
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic write_limit(input int qid, input int limit);
		cfg_wr    = 1'b1;
		cfg_qid   = QID_W'(qid);
		cfg_limit = BYTES_W'(limit);
		@(posedge clk);
		#1;
		cfg_wr = 1'b0;
		ref_limit[qid] = limit;
	endtask

	// wait until every sent result is taken and the output slot is empty
	task automatic wait_drain();
		while (sent_op.size() != 0 || out_valid)
			@(negedge clk);
		@(posedge clk);
		#1;
	endtask

	task automatic check_int(input string what, input int exp, input int act);
		assert (act == exp)
		else begin
			errors++;
			$display("[FAIL] %s: expected %0d, actual %0d", what, exp, act);
		end
	endtask

	// ======================================================================
	// test sequence
	// ======================================================================

	initial begin
		int n;
		int op;
		int qid;
		int len;
		int gap;
		arst_n    = 1'b0;
		in_valid  = 1'b0;
		in_op     = OP_ENQ;
		in_qid    = '0;
		in_len    = '0;
		cfg_wr    = 1'b0;
		cfg_qid   = '0;
		cfg_limit = '0;
		out_ready = 1'b1;
		test_name = "reset";
		for (int q = 0; q < NUM_Q; q++) begin
			ref_bytes[q] = 0;
			ref_pkts[q]  = 0;
			ref_limit[q] = DEF_LIMIT;
		end
		repeat (2) @(posedge clk);
		#1;
		arst_n = 1'b1;
		@(posedge clk);
		#1;

		// idle outputs, then one enq per queue
		assert (!out_valid && in_ready)
		else begin
			errors++;
			$display("after reset out_valid is %0b and in_ready is %0b", out_valid, in_ready);
		end
		test_name = "first_enq";
		for (int q = 0; q < NUM_Q; q++)
			send_cmd(int'(OP_ENQ), q, 100, 0);
		wait_drain();
		check_int("first_enq bytes", 100, last_bytes);

		// queue 3 emptied first so 200+200 lands on 400
		test_name = "limit";
		send_cmd(int'(OP_DEQ), 3, 100, 0);
		wait_drain();
		write_limit(3, 500);
		repeat (3) send_cmd(int'(OP_ENQ), 3, 200, 0);
		wait_drain();
		check_int("limit verdict", int'(VD_DROP), int'(last_verdict));
		check_int("limit bytes", 400, last_bytes);

		// queue 2 holds 100 bytes in one packet
		test_name = "underflow";
		send_cmd(int'(OP_ENQ), 2, 300, 0);
		send_cmd(int'(OP_DEQ), 2, 150, 0);
		send_cmd(int'(OP_DEQ), 2, 250, 0);
		send_cmd(int'(OP_DEQ), 2, 10, 0);
		wait_drain();
		check_int("underflow verdict", int'(VD_UNDERFLOW), int'(last_verdict));
		check_int("underflow bytes", 0, last_bytes);

		// negedges counted from the accept
		test_name = "latency";
		send_cmd(int'(OP_ENQ), 1, 10, 0);
		n = 0;
		while (!out_valid && n < 10) begin
			@(negedge clk);
			n++;
		end
		check_int("latency cycles", 2, n);
		wait_drain();

		// fill until in_ready drops
		test_name = "backpressure";
		rdy_mode  = 1;
		n = 0;
		while (in_ready && n < 16) begin
			op  = rand_below(2);
			qid = rand_below(NUM_Q);
			len = rand_below(600);
			send_cmd(op, qid, len, 0);
			n++;
		end
		assert (!in_ready)
		else begin
			errors++;
			$display("in_ready stayed high with out_ready held low");
		end
		rdy_mode = 2;
		wait_drain();

		test_name = "random";
		for (int i = 0; i < 300; i++) begin
			if (rand_below(25) == 0) begin
				wait_drain();
				qid = rand_below(NUM_Q);
				len = 256 + rand_below(4096);
				write_limit(qid, len);
			end
			op  = (rand_below(5) < 3) ? int'(OP_ENQ) : int'(OP_DEQ);
			qid = rand_below(NUM_Q);
			len = rand_below(1024);
			gap = rand_below(3);
			send_cmd(op, qid, len, gap);
		end
		wait_drain();

		$display("checked %0d results, %0d errors", checked, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* all.f */
enq_pkg.sv
fifo_ctrl.sv
enq_cmd_fifo.sv
queue_limit_regs.sv
enq_engine.sv
enq_top.sv
tb_enq_top.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_enq_top -f all.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "RESULT: PASS"; then
	exit 0
fi
exit 1
